// File: run_sim.sh
#!/usr/bin/env bash
# builds the call arbiter testbench with Verilator, runs it and
# decides pass or fail from the simulation output

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f verilog.f \
        --top-module tb_call_arbiter --Mdir obj_dir -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/sim_tb); then
    echo "$sim_out"
    echo "simulation exited with a failing status"
    exit 1
fi

echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: src/call_arb_config.svh
//##########################################################################
// call arbiter configuration
// sizes of the parent side, the level-one groups, the child side,
// the call fields and the shared queue
//##########################################################################
`ifndef CALL_ARB_CONFIG_SVH
`define CALL_ARB_CONFIG_SVH

// parent side
`define CA_PARENTS            8
`define CA_GROUPS             2
`define CA_PARENTS_PER_GROUP  4

// child side
`define CA_CHILDREN           4
`define CA_THREADS            4

// call fields
`define CA_ARG_W              16
`define CA_ARG_NUM            2
`define CA_PC_W               32

// cells shared by all child lists
`define CA_QUEUE_CELLS        16

`endif

// File: src/call_arb_pkg.sv
//##########################################################################
// call arbiter types
// the fields of one function call and the word kept for a parked call
//##########################################################################
`include "call_arb_config.svh"

package call_arb_pkg;

    // indices
    typedef logic [$clog2(`CA_PARENTS)-1:0]  parent_id_t;
    typedef logic [$clog2(`CA_CHILDREN)-1:0] child_id_t;
    typedef logic [$clog2(`CA_THREADS)-1:0]  thread_id_t;
    typedef logic [$clog2(`CA_GROUPS)-1:0]   group_id_t;

    // payload
    typedef logic [`CA_PC_W-1:0]               pc_t;
    typedef logic [`CA_ARG_W*`CA_ARG_NUM-1:0]  args_t;

    // parked call, the child is implied by the list it sits in
    typedef struct packed {
        parent_id_t parent;
        thread_id_t thread;
        pc_t        pc;
        args_t      args;
    } queue_word_t;

endpackage

// File: src/call_arbiter.sv
//##########################################################################
// call arbiter top
// parent groups feeding level-one slots into the dispatcher that
// delivers one call per cycle to the child functions
//##########################################################################
`timescale 1ns/10ps
`include "call_arb_config.svh"

module call_arbiter import call_arb_pkg::*; (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic       [`CA_PARENTS-1:0]  call_vld_i,
    output logic       [`CA_PARENTS-1:0]  call_rdy_o,
    input  child_id_t  [`CA_PARENTS-1:0]  call_child_i,
    input  thread_id_t [`CA_PARENTS-1:0]  call_thread_i,
    input  pc_t        [`CA_PARENTS-1:0]  call_pc_i,
    input  args_t      [`CA_PARENTS-1:0]  call_args_i,
    input  logic       [`CA_CHILDREN-1:0] child_rdy_i,
    output logic                          call_vld_o,
    output child_id_t                     call_child_o,
    output parent_id_t                    call_parent_o,
    output thread_id_t                    call_thread_o,
    output pc_t                           call_pc_o,
    output args_t                         call_args_o
);
    localparam int PPG = `CA_PARENTS_PER_GROUP;

    // one slot link per group
    group_req_if grp_if [`CA_GROUPS] ();

    for (genvar g = 0; g < `CA_GROUPS; g++) begin : g_group
        parent_group #(
            .FIRST_PARENT (g * PPG)
        ) parent_group_i (
            .clk           (clk),
            .rstn          (rstn),
            .call_vld_i    (call_vld_i[g*PPG +: PPG]),
            .call_child_i  (call_child_i[g*PPG +: PPG]),
            .call_thread_i (call_thread_i[g*PPG +: PPG]),
            .call_pc_i     (call_pc_i[g*PPG +: PPG]),
            .call_args_i   (call_args_i[g*PPG +: PPG]),
            .call_rdy_o    (call_rdy_o[g*PPG +: PPG]),
            .slot          (grp_if[g])
        );
    end

    call_dispatch call_dispatch_i (
        .clk           (clk),
        .rstn          (rstn),
        .grp           (grp_if),
        .child_rdy_i   (child_rdy_i),
        .call_vld_o    (call_vld_o),
        .call_child_o  (call_child_o),
        .call_parent_o (call_parent_o),
        .call_thread_o (call_thread_o),
        .call_pc_o     (call_pc_o),
        .call_args_o   (call_args_o)
    );

endmodule

// File: src/call_dispatch.sv
//##########################################################################
// call dispatcher
// picks a queued call for a ready child or a group slot each cycle,
// parks calls whose child is busy and registers the delivered call
//##########################################################################
`timescale 1ns/10ps
`include "call_arb_config.svh"

module call_dispatch import call_arb_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    group_req_if.dispatch           grp [`CA_GROUPS],
    input  logic [`CA_CHILDREN-1:0] child_rdy_i,
    output logic                    call_vld_o,
    output child_id_t               call_child_o,
    output parent_id_t              call_parent_o,
    output thread_id_t              call_thread_o,
    output pc_t                     call_pc_o,
    output args_t                   call_args_o
);
    localparam int GROUPS   = `CA_GROUPS;
    localparam int CHILDREN = `CA_CHILDREN;

    logic       [GROUPS-1:0] slot_vld;
    parent_id_t [GROUPS-1:0] slot_parent;
    child_id_t  [GROUPS-1:0] slot_child;
    thread_id_t [GROUPS-1:0] slot_thread;
    pc_t        [GROUPS-1:0] slot_pc;
    args_t      [GROUPS-1:0] slot_args;
    logic       [GROUPS-1:0] take;

    child_id_t     child_ptr;
    group_id_t     grp_ptr;
    logic          deq_vld;
    child_id_t     deq_child;
    logic          sel_vld;
    group_id_t     sel_grp;
    child_id_t     sel_child;

    logic          enq;
    logic          deq;
    queue_word_t   enq_word;
    queue_word_t   deq_word;
    logic [CHILDREN-1:0] q_nonempty;
    logic          q_full;

    logic          out_vld;
    child_id_t     out_child;
    queue_word_t   out_word;

    // flatten the slot interfaces so they can be indexed at run time
    for (genvar g = 0; g < GROUPS; g++) begin : g_slot
        assign slot_vld[g]    = grp[g].slot_vld;
        assign slot_parent[g] = grp[g].slot_parent;
        assign slot_child[g]  = grp[g].slot_child;
        assign slot_thread[g] = grp[g].slot_thread;
        assign slot_pc[g]     = grp[g].slot_pc;
        assign slot_args[g]   = grp[g].slot_args;
        assign grp[g].take    = take[g];
    end

    child_queue child_queue_i (
        .clk         (clk),
        .rstn        (rstn),
        .enq_i       (enq),
        .enq_child_i (sel_child),
        .enq_word_i  (enq_word),
        .deq_i       (deq),
        .deq_child_i (deq_child),
        .deq_word_o  (deq_word),
        .nonempty_o  (q_nonempty),
        .full_o      (q_full)
    );

    // round-robin search of ready children with parked calls, and of slots
    always_comb begin
        deq_vld   = 1'b0;
        deq_child = child_ptr;
        for (int i = CHILDREN - 1; i >= 0; i--) begin
            if (q_nonempty[(int'(child_ptr) + i) % CHILDREN] &&
                child_rdy_i[(int'(child_ptr) + i) % CHILDREN]) begin
                deq_vld   = 1'b1;
                deq_child = child_id_t'((int'(child_ptr) + i) % CHILDREN);
            end
        end
        sel_vld = 1'b0;
        sel_grp = grp_ptr;
        for (int i = GROUPS - 1; i >= 0; i--) begin
            if (slot_vld[(int'(grp_ptr) + i) % GROUPS]) begin
                sel_vld = 1'b1;
                sel_grp = group_id_t'((int'(grp_ptr) + i) % GROUPS);
            end
        end
    end

    assign sel_child = slot_child[sel_grp];
    assign enq_word  = '{parent: slot_parent[sel_grp], thread: slot_thread[sel_grp],
                         pc: slot_pc[sel_grp], args: slot_args[sel_grp]};

    // parked calls first, then a slot goes out directly only when
    // nothing older is waiting for its child
    always_comb begin
        take      = '0;
        enq       = 1'b0;
        deq       = 1'b0;
        out_vld   = 1'b0;
        out_child = deq_child;
        out_word  = deq_word;
        if (deq_vld) begin
            deq     = 1'b1;
            out_vld = 1'b1;
        end else if (sel_vld) begin
            out_child = sel_child;
            out_word  = enq_word;
            if (child_rdy_i[sel_child] && !q_nonempty[sel_child]) begin
                take[sel_grp] = 1'b1;
                out_vld       = 1'b1;
            end else if (!q_full) begin
                take[sel_grp] = 1'b1;
                enq           = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            child_ptr  <= '0;
            grp_ptr    <= '0;
            call_vld_o <= 1'b0;
        end else begin
            call_vld_o <= out_vld;
            if (deq) begin
                child_ptr <= child_id_t'((int'(deq_child) + 1) % CHILDREN);
            end
            if (|take) begin
                grp_ptr <= group_id_t'((int'(sel_grp) + 1) % GROUPS);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_vld) begin
            call_child_o  <= out_child;
            call_parent_o <= out_word.parent;
            call_thread_o <= out_word.thread;
            call_pc_o     <= out_word.pc;
            call_args_o   <= out_word.args;
        end
    end

endmodule

// File: src/child_queue.sv
//##########################################################################
// child queue
// linked-list queue, one list per child over a shared pool of cells
// with a free list for cell allocation
//##########################################################################
`timescale 1ns/10ps
`include "call_arb_config.svh"

module child_queue
    import call_arb_pkg::*;
    import link_queue_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    enq_i,
    input  child_id_t               enq_child_i,
    input  queue_word_t             enq_word_i,
    input  logic                    deq_i,
    input  child_id_t               deq_child_i,
    output queue_word_t             deq_word_o,
    output logic [`CA_CHILDREN-1:0] nonempty_o,
    output logic                    full_o
);
    localparam int CELLS = `CA_QUEUE_CELLS;

    queue_word_t cell_mem [CELLS];
    cell_ptr_t   next_ptr [CELLS];
    cell_ptr_t   head [`CA_CHILDREN];
    cell_ptr_t   tail [`CA_CHILDREN];

    logic [`CA_CHILDREN-1:0] nonempty;
    cell_ptr_t               free_head;
    cell_cnt_t               free_cnt;
    cell_ptr_t               enq_cell;
    cell_ptr_t               deq_cell;

    // new calls take the cell at the head of the free list
    assign enq_cell = free_head;
    assign deq_cell = head[deq_child_i];

    assign deq_word_o = cell_mem[deq_cell];
    assign nonempty_o = nonempty;
    assign full_o     = (free_cnt == '0);

    always_ff @(posedge clk) begin
        if (enq_i) begin
            cell_mem[enq_cell] <= enq_word_i;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            // all cells chained into the free list
            for (int i = 0; i < CELLS; i++) begin
                next_ptr[i] <= cell_ptr_t'((i + 1) % CELLS);
            end
            for (int c = 0; c < `CA_CHILDREN; c++) begin
                head[c] <= '0;
                tail[c] <= '0;
            end
            nonempty  <= '0;
            free_head <= '0;
            free_cnt  <= cell_cnt_t'(CELLS);
        end else if (enq_i) begin
            free_head <= next_ptr[enq_cell];
            free_cnt  <= free_cnt - 1'b1;
            // append behind the current tail, or start a fresh list
            if (nonempty[enq_child_i]) begin
                next_ptr[tail[enq_child_i]] <= enq_cell;
            end else begin
                head[enq_child_i] <= enq_cell;
            end
            tail[enq_child_i]     <= enq_cell;
            nonempty[enq_child_i] <= 1'b1;
        end else if (deq_i) begin
            head[deq_child_i] <= next_ptr[deq_cell];
            // last element when head and tail meet
            if (deq_cell == tail[deq_child_i]) begin
                nonempty[deq_child_i] <= 1'b0;
            end
            // released cell goes back on top of the free list
            next_ptr[deq_cell] <= free_head;
            free_head          <= deq_cell;
            free_cnt           <= free_cnt + 1'b1;
        end
    end

endmodule

// File: src/group_req_if.sv
//##########################################################################
// group slot interface
// one level-one slot offered by a parent group to the dispatcher
//##########################################################################
`timescale 1ns/10ps

interface group_req_if import call_arb_pkg::*; ();

    logic       slot_vld;
    parent_id_t slot_parent;
    child_id_t  slot_child;
    thread_id_t slot_thread;
    pc_t        slot_pc;
    args_t      slot_args;
    // slot is emptied at the edge that ends a take cycle
    logic       take;

    modport group (
        output slot_vld, slot_parent, slot_child, slot_thread, slot_pc, slot_args,
        input  take
    );

    modport dispatch (
        input  slot_vld, slot_parent, slot_child, slot_thread, slot_pc, slot_args,
        output take
    );

endinterface

// File: src/link_queue_pkg.sv
//##########################################################################
// linked-list queue types
// addressing and free-cell accounting of the shared cell storage
//##########################################################################
`include "call_arb_config.svh"

package link_queue_pkg;

    // address of one cell
    typedef logic [$clog2(`CA_QUEUE_CELLS)-1:0] cell_ptr_t;

    // one extra bit so that a fully free storage can be counted
    typedef logic [$clog2(`CA_QUEUE_CELLS):0]   cell_cnt_t;

endpackage

// File: src/parent_group.sv
//##########################################################################
// parent group
// one-entry buffer per parent port and round-robin fill of the group's
// level-one slot
//##########################################################################
`timescale 1ns/10ps
`include "call_arb_config.svh"

module parent_group import call_arb_pkg::*; #(
    parameter int FIRST_PARENT = 0
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic       [`CA_PARENTS_PER_GROUP-1:0] call_vld_i,
    input  child_id_t  [`CA_PARENTS_PER_GROUP-1:0] call_child_i,
    input  thread_id_t [`CA_PARENTS_PER_GROUP-1:0] call_thread_i,
    input  pc_t        [`CA_PARENTS_PER_GROUP-1:0] call_pc_i,
    input  args_t      [`CA_PARENTS_PER_GROUP-1:0] call_args_i,
    output logic       [`CA_PARENTS_PER_GROUP-1:0] call_rdy_o,
    group_req_if.group                           slot
);
    localparam int PPG   = `CA_PARENTS_PER_GROUP;
    localparam int IDX_W = $clog2(PPG);

    logic       [PPG-1:0] buf_vld;
    child_id_t  [PPG-1:0] buf_child;
    thread_id_t [PPG-1:0] buf_thread;
    pc_t        [PPG-1:0] buf_pc;
    args_t      [PPG-1:0] buf_args;

    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] pick_idx;
    logic             pick_vld;
    logic             fill;

    assign call_rdy_o = ~buf_vld;

    // first buffered parent at or after the pointer
    always_comb begin
        pick_vld = 1'b0;
        pick_idx = rr_ptr;
        for (int i = PPG - 1; i >= 0; i--) begin
            if (buf_vld[(int'(rr_ptr) + i) % PPG]) begin
                pick_vld = 1'b1;
                pick_idx = IDX_W'((int'(rr_ptr) + i) % PPG);
            end
        end
    end

    assign fill = pick_vld && !slot.slot_vld;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_vld <= '0;
        end else begin
            for (int p = 0; p < PPG; p++) begin
                if (call_vld_i[p] && !buf_vld[p]) begin
                    buf_vld[p] <= 1'b1;
                end else if (fill && (pick_idx == IDX_W'(p))) begin
                    buf_vld[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < PPG; p++) begin
            if (call_vld_i[p] && !buf_vld[p]) begin
                buf_child[p]  <= call_child_i[p];
                buf_thread[p] <= call_thread_i[p];
                buf_pc[p]     <= call_pc_i[p];
                buf_args[p]   <= call_args_i[p];
            end
        end
    end

    // slot state, pointer moves past the winner only on a fill
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot.slot_vld <= 1'b0;
            rr_ptr        <= '0;
        end else if (fill) begin
            slot.slot_vld <= 1'b1;
            rr_ptr        <= IDX_W'((int'(pick_idx) + 1) % PPG);
        end else if (slot.take) begin
            slot.slot_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            slot.slot_parent <= parent_id_t'(FIRST_PARENT + int'(pick_idx));
            slot.slot_child  <= buf_child[pick_idx];
            slot.slot_thread <= buf_thread[pick_idx];
            slot.slot_pc     <= buf_pc[pick_idx];
            slot.slot_args   <= buf_args[pick_idx];
        end
    end

endmodule

// File: verification/tb_call_arbiter.sv
//##########################################################################
// call arbiter testbench
// directed tests with a per-parent scoreboard, readiness check on every
// delivered call and a cycle limit on the whole run
//##########################################################################
`timescale 1ns/10ps
`include "call_arb_config.svh"

module tb_call_arbiter import call_arb_pkg::*; ();
    localparam int PARENTS      = `CA_PARENTS;
    localparam int CHILDREN     = `CA_CHILDREN;
    localparam int RESET_CYCLES = 10;
    localparam int LEN_RESET    = 10;
    localparam int LEN_SINGLE   = 50;
    localparam int HOLD_BLOCK   = 40;
    localparam int LEN_BLOCK    = 150;
    localparam int LEN_ALL      = 100;
    localparam int HOLD_BP      = 60;
    localparam int LEN_BP       = 200;
    localparam int RAND_CYCLES  = 300;
    localparam int LEN_RAND     = 200;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + LEN_RESET + LEN_SINGLE + HOLD_BLOCK +
                                         LEN_BLOCK + LEN_ALL + HOLD_BP + LEN_BP +
                                         RAND_CYCLES + LEN_RAND);
    localparam logic [31:0] LFSR_MASK = 32'h80200003;

    typedef struct packed {
        child_id_t  child;
        thread_id_t thread;
        pc_t        pc;
        args_t      args;
    } call_rec_t;

    logic                          clk = 1'b0;
    logic                          rstn;
    logic       [PARENTS-1:0]      call_vld_i = '0;
    logic       [PARENTS-1:0]      call_rdy_o;
    child_id_t  [PARENTS-1:0]      call_child_i = '0;
    thread_id_t [PARENTS-1:0]      call_thread_i = '0;
    pc_t        [PARENTS-1:0]      call_pc_i = '0;
    args_t      [PARENTS-1:0]      call_args_i = '0;
    logic       [CHILDREN-1:0]     child_rdy_i;
    logic                          call_vld_o;
    child_id_t                     call_child_o;
    parent_id_t                    call_parent_o;
    thread_id_t                    call_thread_o;
    pc_t                           call_pc_o;
    args_t                         call_args_o;

    // calls waiting to be offered, and accepted calls waiting to come out
    call_rec_t offer_q [PARENTS][$];
    call_rec_t exp_q   [PARENTS][$];

    logic [31:0]         lfsr = 32'he874e9e9;
    logic [CHILDREN-1:0] prev_rdy = '0;
    int                  errors = 0;
    int                  err_mark = 0;
    int                  tests_run = 0;
    int                  deliveries = 0;
    int                  cycle_cnt = 0;

    call_arbiter call_arbiter_i (
        .clk           (clk),
        .rstn          (rstn),
        .call_vld_i    (call_vld_i),
        .call_rdy_o    (call_rdy_o),
        .call_child_i  (call_child_i),
        .call_thread_i (call_thread_i),
        .call_pc_i     (call_pc_i),
        .call_args_i   (call_args_i),
        .child_rdy_i   (child_rdy_i),
        .call_vld_o    (call_vld_o),
        .call_child_o  (call_child_o),
        .call_parent_o (call_parent_o),
        .call_thread_o (call_thread_o),
        .call_pc_o     (call_pc_o),
        .call_args_o   (call_args_o)
    );

    always #5 clk = ~clk;

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_MASK) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        $display("test %-10s done with %0d errors", name, errors - err_mark);
        err_mark = errors;
        tests_run++;
    endtask

    task automatic offer_call(input int p, input child_id_t child, input thread_id_t thr,
                              input pc_t pc, input args_t args);
        call_rec_t c;
        c.child  = child;
        c.thread = thr;
        c.pc     = pc;
        c.args   = args;
        offer_q[p].push_back(c);
    endtask

    task automatic offer_random(input int p);
        child_id_t  child;
        thread_id_t thr;
        pc_t        pc;
        args_t      args;
        child = child_id_t'(rand_bits(2));
        thr   = thread_id_t'(rand_bits(2));
        pc    = rand_bits(32);
        args  = rand_bits(32);
        offer_call(p, child, thr, pc, args);
    endtask

    function automatic bit all_drained();
        for (int p = 0; p < PARENTS; p++) begin
            if (offer_q[p].size() != 0 || exp_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // waits for every offered call to come out, then flags what is left
    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (!all_drained() && n < limit) begin
            @(negedge clk);
            n++;
        end
        for (int p = 0; p < PARENTS; p++) begin
            if (exp_q[p].size() != 0) begin
                report_error($sformatf("parent %0d still misses %0d accepted calls",
                                       p, exp_q[p].size()));
            end
            if (offer_q[p].size() != 0) begin
                report_error($sformatf("parent %0d had %0d calls that were never accepted",
                                       p, offer_q[p].size()));
            end
            exp_q[p].delete();
            offer_q[p].delete();
        end
    endtask

    // presents the oldest waiting call of each parent
    always @(posedge clk) begin
        for (int p = 0; p < PARENTS; p++) begin
            if (offer_q[p].size() > 0) begin
                call_vld_i[p]    <= 1'b1;
                call_child_i[p]  <= offer_q[p][0].child;
                call_thread_i[p] <= offer_q[p][0].thread;
                call_pc_i[p]     <= offer_q[p][0].pc;
                call_args_i[p]   <= offer_q[p][0].args;
            end else begin
                call_vld_i[p] <= 1'b0;
            end
        end
    end

    // a parent's calls to one child keep their order, calls to different
    // children may pass each other while one child is parked
    always @(negedge clk) begin : monitor
        call_rec_t c;
        int        p;
        int        hit;
        if (rstn) begin
            for (int q = 0; q < PARENTS; q++) begin
                if (call_vld_i[q] && call_rdy_o[q]) begin
                    c.child  = call_child_i[q];
                    c.thread = call_thread_i[q];
                    c.pc     = call_pc_i[q];
                    c.args   = call_args_i[q];
                    exp_q[q].push_back(c);
                    void'(offer_q[q].pop_front());
                end
            end
            if (call_vld_o) begin
                deliveries++;
                p   = int'(call_parent_o);
                hit = -1;
                for (int i = exp_q[p].size() - 1; i >= 0; i--) begin
                    if (exp_q[p][i].child == call_child_o) begin
                        hit = i;
                    end
                end
                if (!prev_rdy[call_child_o]) begin
                    report_error($sformatf("call delivered to child %0d that was not ready",
                                           call_child_o));
                end
                if (hit < 0) begin
                    report_error($sformatf("parent %0d delivered a call to child %0d it never made",
                                           p, call_child_o));
                end else begin
                    check_value("call_thread_o", call_thread_o, exp_q[p][hit].thread);
                    check_value("call_pc_o", call_pc_o, exp_q[p][hit].pc);
                    check_value("call_args_o", call_args_o, exp_q[p][hit].args);
                    exp_q[p].delete(hit);
                end
            end
            prev_rdy = child_rdy_i;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Error: run stopped at cycle %0d before the tests finished", cycle_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic test_reset();
        repeat (LEN_RESET) begin
            @(negedge clk);
            check_value("call_vld_o", call_vld_o, 1'b0);
            check_value("call_rdy_o", call_rdy_o, {PARENTS{1'b1}});
        end
        end_test("reset");
    endtask

    task automatic test_single();
        int d0;
        d0 = deliveries;
        @(negedge clk);
        offer_call(5, 2'd2, 2'd3, 32'h1234_5678, 32'hbeef_0001);
        wait_drained(LEN_SINGLE);
        check_value("deliveries", deliveries - d0, 1);
        end_test("single");
    endtask

    task automatic test_blocked();
        int blk_parents [4] = '{0, 2, 5, 7};
        @(posedge clk);
        child_rdy_i <= 4'b1101;
        @(negedge clk);
        for (int n = 0; n < 3; n++) begin
            foreach (blk_parents[k]) begin
                offer_call(blk_parents[k], 2'd1, thread_id_t'(n),
                           {8'(blk_parents[k]), 24'(n)}, 32'hb10c_0000 | n);
            end
            offer_call(3, 2'd0, 2'd0, 32'h0003_0000 + n, 32'h0);
        end
        repeat (HOLD_BLOCK) @(negedge clk);
        // calls to a ready child flow past the parked ones
        check_value("parent 3 outstanding", exp_q[3].size() + offer_q[3].size(), 0);
        @(posedge clk);
        child_rdy_i <= '1;
        wait_drained(LEN_BLOCK);
        end_test("blocked");
    endtask

    task automatic test_all_parents();
        @(negedge clk);
        for (int n = 0; n < 2; n++) begin
            for (int p = 0; p < PARENTS; p++) begin
                offer_random(p);
            end
        end
        wait_drained(LEN_ALL);
        end_test("all");
    endtask

    task automatic test_backpressure();
        int d0;
        int held;
        @(posedge clk);
        child_rdy_i <= '0;
        d0 = deliveries;
        @(negedge clk);
        for (int n = 0; n < 5; n++) begin
            for (int p = 0; p < PARENTS; p++) begin
                offer_random(p);
            end
        end
        repeat (HOLD_BP) @(negedge clk);
        // every queue cell, level-one slot and parent buffer holds a call
        held = 0;
        for (int p = 0; p < PARENTS; p++) begin
            held += exp_q[p].size();
        end
        check_value("call_rdy_o", call_rdy_o, '0);
        check_value("calls held while blocked", held,
                    `CA_QUEUE_CELLS + `CA_GROUPS + `CA_PARENTS);
        check_value("deliveries while blocked", deliveries - d0, 0);
        @(posedge clk);
        child_rdy_i <= '1;
        wait_drained(LEN_BP);
        end_test("backpress");
    endtask

    task automatic test_random();
        repeat (RAND_CYCLES) begin
            @(posedge clk);
            child_rdy_i <= 4'(rand_bits(4) | rand_bits(4));
            @(negedge clk);
            for (int p = 0; p < PARENTS; p++) begin
                if (rand_bits(3) == 0 && offer_q[p].size() < 3) begin
                    offer_random(p);
                end
            end
        end
        @(posedge clk);
        child_rdy_i <= '1;
        wait_drained(LEN_RAND);
        end_test("random");
    endtask

    initial begin
        rstn        = 1'b0;
        child_rdy_i = '1;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        test_reset();
        test_single();
        test_blocked();
        test_all_parents();
        test_backpressure();
        test_random();
        $display("tests run %0d, calls delivered %0d, errors %0d",
                 tests_run, deliveries, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
src/call_arb_pkg.sv
src/link_queue_pkg.sv
src/group_req_if.sv
src/parent_group.sv
src/child_queue.sv
src/call_dispatch.sv
src/call_arbiter.sv
verification/tb_call_arbiter.sv
